/* Makefile */
# Verilator build and run for the packet router testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -f files.f --top-module packet_router_tb -o Vpacket_router_tb

# Pass only if the simulation printed the pass line
run: compile
	@out="$$(./obj_dir/Vpacket_router_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Done: no errors$$"

clean:
	rm -rf obj_dir

/* files.f */
rtl/router_pkg.sv
rtl/ing_port_buffer.sv
rtl/ing_arbiter.sv
rtl/route_lookup.sv
rtl/egr_port_steer.sv
rtl/packet_router.sv
verification/packet_router_sva.sv
verification/packet_router_tb.sv

/* rtl/egr_port_steer.sv */
////////////////////////////////////////
// Egress port steer
// Credit-gated egress, dropped packets absorbed and counted
////////////////////////////////////////

`default_nettype none

module egr_port_steer import router_pkg::*; #(
    parameter int DATA_W      = 32,
    parameter int EGR_CREDITS = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 lk_valid,
    input  logic [DATA_W-1:0]    lk_data,
    input  logic                 lk_last,
    input  ing_idx_t             lk_src,
    input  egr_idx_t             lk_port,
    input  logic                 lk_drop,
    output logic                 lk_ready,

    output logic [EGR_PORTS-1:0] egr_valid,
    output logic [EGR_PORTS-1:0] egr_last,
    output logic [DATA_W-1:0]    egr_data,
    output ing_idx_t             egr_src,
    input  logic [EGR_PORTS-1:0] egr_credit,

    output logic [15:0]          drop_count
);

    localparam int CNT_W = $clog2(EGR_CREDITS + 1);

    logic [CNT_W-1:0]     credit_cnt [EGR_PORTS];
    logic [EGR_PORTS-1:0] has_credit;
    logic                 fwd;
    logic                 drop;

    // A beat already on the wire holds one of the credits
    always_comb begin
        for (int p = 0; p < EGR_PORTS; p++) begin
            has_credit[p] = credit_cnt[p] > CNT_W'(egr_valid[p]);
        end
    end

    // Dropped beats never wait for credit
    assign lk_ready = lk_drop || has_credit[lk_port];
    assign fwd      = lk_valid && !lk_drop && has_credit[lk_port];
    assign drop     = lk_valid && lk_drop;

    ////////////////////////////////////////
    // Credit counters

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < EGR_PORTS; p++) begin
                credit_cnt[p] <= CNT_W'(EGR_CREDITS);
            end
        end else begin
            for (int p = 0; p < EGR_PORTS; p++) begin
                credit_cnt[p] <= credit_cnt[p] - CNT_W'(egr_valid[p])
                                 + CNT_W'(egr_credit[p]);
            end
        end
    end

    ////////////////////////////////////////
    // Egress beats

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            egr_valid <= '0;
        end else begin
            for (int p = 0; p < EGR_PORTS; p++) begin
                egr_valid[p] <= fwd && (lk_port == egr_idx_t'(p));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fwd) begin
            egr_data          <= lk_data;
            egr_src           <= lk_src;
            egr_last[lk_port] <= lk_last;
        end
    end

    // One count per dropped packet, on its last beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drop_count <= '0;
        end else if (drop && lk_last) begin
            drop_count <= drop_count + 16'd1;
        end
    end

endmodule

`default_nettype wire

/* rtl/ing_arbiter.sv */
////////////////////////////////////////
// Ingress arbiter
// Round-robin packet merge, tags each packet with its port
////////////////////////////////////////

`default_nettype none

module ing_arbiter import router_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic [ING_PORTS-1:0] buf_valid,
    input  logic [DATA_W-1:0]    buf_data [ING_PORTS],
    input  logic [ING_PORTS-1:0] buf_last,
    output logic [ING_PORTS-1:0] buf_ready,

    output logic                 arb_valid,
    output logic [DATA_W-1:0]    arb_data,
    output logic                 arb_last,
    output ing_idx_t             arb_src,
    input  logic                 arb_ready
);

    logic     locked;
    ing_idx_t owner;
    ing_idx_t last_grant;
    ing_idx_t pick;
    ing_idx_t sel;
    logic     out_free;
    logic     take;

    ////////////////////////////////////////
    // Grant selection

    // Other port first, so both waiting means alternate
    always_comb begin
        if (buf_valid[~last_grant]) begin
            pick = ~last_grant;
        end else begin
            pick = last_grant;
        end
    end

    // Held for the whole packet once granted
    assign sel      = locked ? owner : pick;
    assign out_free = !arb_valid || arb_ready;
    assign take     = out_free && buf_valid[sel];

    always_comb begin
        for (int i = 0; i < ING_PORTS; i++) begin
            buf_ready[i] = out_free && (sel == ing_idx_t'(i));
        end
    end

    ////////////////////////////////////////
    // Output stage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arb_valid  <= 1'b0;
            locked     <= 1'b0;
            owner      <= '0;
            last_grant <= '0;
        end else if (take) begin
            arb_valid <= 1'b1;
            locked    <= !buf_last[sel];
            owner     <= sel;
            if (buf_last[sel]) begin
                last_grant <= sel;
            end
        end else if (arb_ready) begin
            arb_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            arb_data <= buf_data[sel];
            arb_last <= buf_last[sel];
            arb_src  <= sel;
        end
    end

endmodule

`default_nettype wire

/* rtl/ing_port_buffer.sv */
////////////////////////////////////////
// Ingress port buffer
// Credit-fed FIFO, one credit back per beat popped
////////////////////////////////////////

`default_nettype none

module ing_port_buffer #(
    parameter int DATA_W    = 32,
    parameter int BUF_DEPTH = 8
) (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              in_valid,
    input  logic [DATA_W-1:0] in_data,
    input  logic              in_last,
    output logic              credit,

    output logic              buf_valid,
    output logic [DATA_W-1:0] buf_data,
    output logic              buf_last,
    input  logic              buf_ready
);

    localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    logic [DATA_W-1:0] mem_data [BUF_DEPTH];
    logic              mem_last [BUF_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  fill;
    logic              push;
    logic              pop;

    // Wrap at BUF_DEPTH, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(BUF_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // A sender within its credits never finds the buffer full
    assign push = in_valid && (fill != CNT_W'(BUF_DEPTH));
    assign pop  = buf_valid && buf_ready;

    assign buf_valid = (fill != '0);
    assign buf_data  = mem_data[rd_ptr];
    assign buf_last  = mem_last[rd_ptr];

    ////////////////////////////////////////
    // Storage

    always_ff @(posedge clk) begin
        if (push) begin
            mem_data[wr_ptr] <= in_data;
            mem_last[wr_ptr] <= in_last;
        end
    end

    ////////////////////////////////////////
    // Pointers, fill level and credit return

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            // Credit goes back the cycle after the pop
            credit <= pop;
        end
    end

endmodule

`default_nettype wire

/* rtl/packet_router.sv */
////////////////////////////////////////
// Packet router top level
// Ingress buffers, arbiter, route lookup and egress steer
////////////////////////////////////////

`default_nettype none

module packet_router import router_pkg::*; #(
    parameter int DATA_W      = 32,
    parameter int BUF_DEPTH   = 8,
    parameter int EGR_CREDITS = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic [ING_PORTS-1:0] ing_valid,
    input  logic [DATA_W-1:0]    ing_data [ING_PORTS],
    input  logic [ING_PORTS-1:0] ing_last,
    output logic [ING_PORTS-1:0] ing_credit,

    input  logic                 cfg_wr,
    input  logic [KEY_W-1:0]     cfg_key,
    input  egr_idx_t             cfg_port,
    input  logic                 cfg_en,

    output logic [EGR_PORTS-1:0] egr_valid,
    output logic [EGR_PORTS-1:0] egr_last,
    input  logic [EGR_PORTS-1:0] egr_credit,
    output logic [DATA_W-1:0]    egr_data,
    output ing_idx_t             egr_src,

    output logic [15:0]          drop_count
);

    logic [ING_PORTS-1:0] buf_valid;
    logic [DATA_W-1:0]    buf_data [ING_PORTS];
    logic [ING_PORTS-1:0] buf_last;
    logic [ING_PORTS-1:0] buf_ready;

    logic                 arb_valid;
    logic [DATA_W-1:0]    arb_data;
    logic                 arb_last;
    ing_idx_t             arb_src;
    logic                 arb_ready;

    logic                 lk_valid;
    logic [DATA_W-1:0]    lk_data;
    logic                 lk_last;
    ing_idx_t             lk_src;
    egr_idx_t             lk_port;
    logic                 lk_drop;
    logic                 lk_ready;

    ////////////////////////////////////////
    // Ingress

    for (genvar i = 0; i < ING_PORTS; i++) begin : g_ing
        ing_port_buffer #(
            .DATA_W    ( DATA_W    ),
            .BUF_DEPTH ( BUF_DEPTH )
        ) buf_i (
            .clk       ( clk           ),
            .rst_n     ( rst_n         ),
            .in_valid  ( ing_valid[i]  ),
            .in_data   ( ing_data[i]   ),
            .in_last   ( ing_last[i]   ),
            .credit    ( ing_credit[i] ),
            .buf_valid ( buf_valid[i]  ),
            .buf_data  ( buf_data[i]   ),
            .buf_last  ( buf_last[i]   ),
            .buf_ready ( buf_ready[i]  )
        );
    end

    ing_arbiter #(
        .DATA_W    ( DATA_W )
    ) arb_i (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .buf_valid ( buf_valid ),
        .buf_data  ( buf_data  ),
        .buf_last  ( buf_last  ),
        .buf_ready ( buf_ready ),
        .arb_valid ( arb_valid ),
        .arb_data  ( arb_data  ),
        .arb_last  ( arb_last  ),
        .arb_src   ( arb_src   ),
        .arb_ready ( arb_ready )
    );

    ////////////////////////////////////////
    // Lookup

    route_lookup #(
        .DATA_W    ( DATA_W )
    ) lookup_i (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .cfg_wr    ( cfg_wr    ),
        .cfg_key   ( cfg_key   ),
        .cfg_port  ( cfg_port  ),
        .cfg_en    ( cfg_en    ),
        .arb_valid ( arb_valid ),
        .arb_data  ( arb_data  ),
        .arb_last  ( arb_last  ),
        .arb_src   ( arb_src   ),
        .arb_ready ( arb_ready ),
        .lk_valid  ( lk_valid  ),
        .lk_data   ( lk_data   ),
        .lk_last   ( lk_last   ),
        .lk_src    ( lk_src    ),
        .lk_port   ( lk_port   ),
        .lk_drop   ( lk_drop   ),
        .lk_ready  ( lk_ready  )
    );

    ////////////////////////////////////////
    // Egress

    egr_port_steer #(
        .DATA_W      ( DATA_W      ),
        .EGR_CREDITS ( EGR_CREDITS )
    ) steer_i (
        .clk         ( clk        ),
        .rst_n       ( rst_n      ),
        .lk_valid    ( lk_valid   ),
        .lk_data     ( lk_data    ),
        .lk_last     ( lk_last    ),
        .lk_src      ( lk_src     ),
        .lk_port     ( lk_port    ),
        .lk_drop     ( lk_drop    ),
        .lk_ready    ( lk_ready   ),
        .egr_valid   ( egr_valid  ),
        .egr_last    ( egr_last   ),
        .egr_data    ( egr_data   ),
        .egr_src     ( egr_src    ),
        .egr_credit  ( egr_credit ),
        .drop_count  ( drop_count )
    );

endmodule

`default_nettype wire

/* rtl/route_lookup.sv */
////////////////////////////////////////
// Route lookup
// Key table picks the egress port or drop per packet
////////////////////////////////////////

`default_nettype none

module route_lookup import router_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              cfg_wr,
    input  logic [KEY_W-1:0]  cfg_key,
    input  egr_idx_t          cfg_port,
    input  logic              cfg_en,

    input  logic              arb_valid,
    input  logic [DATA_W-1:0] arb_data,
    input  logic              arb_last,
    input  ing_idx_t          arb_src,
    output logic              arb_ready,

    output logic              lk_valid,
    output logic [DATA_W-1:0] lk_data,
    output logic              lk_last,
    output ing_idx_t          lk_src,
    output egr_idx_t          lk_port,
    output logic              lk_drop,
    input  logic              lk_ready
);

    localparam int TBL_SIZE = 2 ** KEY_W;

    logic [TBL_SIZE-1:0] tbl_en;
    egr_idx_t            tbl_port [TBL_SIZE];
    logic                in_pkt;
    logic [KEY_W-1:0]    key;
    logic                take;
    egr_idx_t            port_sel;
    logic                drop_sel;

    assign arb_ready = !lk_valid || lk_ready;
    assign take      = arb_valid && arb_ready;
    assign key       = arb_data[KEY_W-1:0];

    // Later beats reuse what the first beat loaded
    always_comb begin
        if (in_pkt) begin
            port_sel = lk_port;
            drop_sel = lk_drop;
        end else begin
            port_sel = tbl_port[key];
            drop_sel = !tbl_en[key];
        end
    end

    ////////////////////////////////////////
    // Route table

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tbl_en <= '0;
        end else if (cfg_wr) begin
            tbl_en[cfg_key] <= cfg_en;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_wr) begin
            tbl_port[cfg_key] <= cfg_port;
        end
    end

    ////////////////////////////////////////
    // Output stage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lk_valid <= 1'b0;
            in_pkt   <= 1'b0;
        end else if (take) begin
            lk_valid <= 1'b1;
            in_pkt   <= !arb_last;
        end else if (lk_ready) begin
            lk_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            lk_data <= arb_data;
            lk_last <= arb_last;
            lk_src  <= arb_src;
            lk_port <= port_sel;
            lk_drop <= drop_sel;
        end
    end

endmodule

`default_nettype wire

/* rtl/router_pkg.sv */
////////////////////////////////////////
// Router package
// Port counts, route key width and port index types
////////////////////////////////////////

`default_nettype none

package router_pkg;

    ////////////////////////////////////////
    // Port counts

    // Two ingress buffers feed the arbiter
    localparam int ING_PORTS = 2;

    // Two egress ports leave the steer stage
    localparam int EGR_PORTS = 2;

    ////////////////////////////////////////
    // Route key

    // Low bits of a packet's first beat
    localparam int KEY_W = 4;

    ////////////////////////////////////////
    // Port index types

    typedef logic [$clog2(ING_PORTS)-1:0] ing_idx_t;

    typedef logic [$clog2(EGR_PORTS)-1:0] egr_idx_t;

endpackage

`default_nettype wire

/* verification/packet_router_sva.sv */
////////////////////////////////////////
// Packet router assertions
// Credit and egress framing rules
////////////////////////////////////////

`default_nettype none

module packet_router_sva import router_pkg::*; #(
    parameter int BUF_DEPTH   = 8,
    parameter int EGR_CREDITS = 4
) (
    input logic                 clk,
    input logic                 rst_n,
    input logic [ING_PORTS-1:0] ing_valid,
    input logic [ING_PORTS-1:0] ing_credit,
    input logic [EGR_PORTS-1:0] egr_valid,
    input logic [EGR_PORTS-1:0] egr_last,
    input logic [EGR_PORTS-1:0] egr_credit,
    input ing_idx_t             egr_src
);

    timeunit 1ns;
    timeprecision 100ps;

    int                   ing_out [ING_PORTS];
    int                   egr_cnt [EGR_PORTS];
    logic [EGR_PORTS-1:0] in_pkt;
    ing_idx_t             pkt_src [EGR_PORTS];

    // Shadow of outstanding ingress beats and egress credits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ING_PORTS; i++) begin
                ing_out[i] <= 0;
            end
            for (int p = 0; p < EGR_PORTS; p++) begin
                egr_cnt[p] <= EGR_CREDITS;
                pkt_src[p] <= '0;
            end
            in_pkt <= '0;
        end else begin
            for (int i = 0; i < ING_PORTS; i++) begin
                ing_out[i] <= ing_out[i] + int'(ing_valid[i]) - int'(ing_credit[i]);
            end
            for (int p = 0; p < EGR_PORTS; p++) begin
                egr_cnt[p] <= egr_cnt[p] - int'(egr_valid[p]) + int'(egr_credit[p]);
                if (egr_valid[p]) begin
                    in_pkt[p]  <= !egr_last[p];
                    pkt_src[p] <= egr_src;
                end
            end
        end
    end

    for (genvar i = 0; i < ING_PORTS; i++) begin : g_ing
        a_credit_owed: assert property (@(posedge clk) disable iff (!rst_n)
            ing_credit[i] |-> ing_out[i] > 0)
            else $error("ingress %0d returned a credit with no beat outstanding", i);
    end

    for (genvar p = 0; p < EGR_PORTS; p++) begin : g_egr
        a_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
            egr_valid[p] |-> egr_cnt[p] > 0)
            else $error("egress %0d sent a beat with no credit", p);
        a_same_src: assert property (@(posedge clk) disable iff (!rst_n)
            egr_valid[p] && in_pkt[p] |-> egr_src == pkt_src[p])
            else $error("egress %0d changed source inside a packet", p);
        a_no_mix: assert property (@(posedge clk) disable iff (!rst_n)
            egr_valid[p] |-> (in_pkt & ~(EGR_PORTS'(1) << p)) == '0)
            else $error("egress %0d started while another port was mid-packet", p);
    end

endmodule

bind packet_router packet_router_sva #(
    .BUF_DEPTH   ( BUF_DEPTH   ),
    .EGR_CREDITS ( EGR_CREDITS )
) sva_i (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .ing_valid  ( ing_valid  ),
    .ing_credit ( ing_credit ),
    .egr_valid  ( egr_valid  ),
    .egr_last   ( egr_last   ),
    .egr_credit ( egr_credit ),
    .egr_src    ( egr_src    )
);

`default_nettype wire

/* verification/packet_router_tb.sv */
////////////////////////////////////////
// Packet router testbench
// Table-driven packets, credit models and scoreboard
////////////////////////////////////////

`default_nettype none

module packet_router_tb import router_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DATA_W      = 32;
    localparam int BUF_DEPTH   = 8;
    localparam int EGR_CREDITS = 4;
    localparam int SEED        = 81;
    localparam int DRAIN_LIMIT = 400;
    localparam int HOLD_PHASE  = 2;
    localparam int HOLD_CYCLES = 30;
    localparam int PHASES      = 4;
    localparam int NROWS       = 11;
    localparam int QUEUES      = EGR_PORTS * ING_PORTS;

    typedef struct packed {
        logic [1:0]       phase;
        ing_idx_t         ing;
        logic [KEY_W-1:0] key;
        logic [3:0]       len;
        logic             prog;
        logic             prog_en;
        egr_idx_t         prog_port;
        logic             exp_drop;
        egr_idx_t         exp_port;
    } row_t;

    // phase, ingress, key, length, program, enable, program port, drop, egress port
    localparam row_t ROWS [NROWS] = '{
        '{2'd0, 1'b0, 4'd3, 4'd4, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1},
        '{2'd0, 1'b0, 4'd5, 4'd1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0},
        '{2'd1, 1'b1, 4'd7, 4'd3, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0},
        '{2'd1, 1'b0, 4'd9, 4'd2, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0},
        '{2'd2, 1'b0, 4'd3, 4'd6, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1},
        '{2'd2, 1'b1, 4'd5, 4'd5, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{2'd2, 1'b0, 4'd5, 4'd3, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{2'd2, 1'b1, 4'd3, 4'd4, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1},
        '{2'd2, 1'b1, 4'd7, 4'd2, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0},
        '{2'd3, 1'b0, 4'd3, 4'd3, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0},
        '{2'd3, 1'b1, 4'd3, 4'd2, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0}
    };

    logic                 clk;
    logic                 rst_n;
    logic [ING_PORTS-1:0] ing_valid;
    logic [DATA_W-1:0]    ing_data [ING_PORTS];
    logic [ING_PORTS-1:0] ing_last;
    logic [ING_PORTS-1:0] ing_credit;
    logic                 cfg_wr;
    logic [KEY_W-1:0]     cfg_key;
    egr_idx_t             cfg_port;
    logic                 cfg_en;
    logic [EGR_PORTS-1:0] egr_valid;
    logic [EGR_PORTS-1:0] egr_last;
    logic [EGR_PORTS-1:0] egr_credit;
    logic [DATA_W-1:0]    egr_data;
    ing_idx_t             egr_src;
    logic [15:0]          drop_count;

    // Sender queues, expected queues per egress port and source
    logic [DATA_W:0]      snd_q [ING_PORTS][$];
    logic [DATA_W:0]      exp_q [QUEUES][$];
    int                   snd_rd [ING_PORTS];
    int                   sent [ING_PORTS];
    int                   credits_back [ING_PORTS];
    int                   exp_rd [QUEUES];
    int                   beats_seen [EGR_PORTS];
    int                   credits_sent [EGR_PORTS];
    int                   gap [EGR_PORTS];
    logic [EGR_PORTS-1:0] in_pkt;
    ing_idx_t             cur_src [EGR_PORTS];
    logic                 hold;
    logic [2**KEY_W-1:0]  shadow_en;
    egr_idx_t             shadow_port [2**KEY_W];
    int                   errors;
    int                   stream_errors;
    int                   timeouts;
    int                   exp_drops;

    packet_router #(
        .DATA_W      ( DATA_W      ),
        .BUF_DEPTH   ( BUF_DEPTH   ),
        .EGR_CREDITS ( EGR_CREDITS )
    ) dut_i (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .ing_valid  ( ing_valid  ),
        .ing_data   ( ing_data   ),
        .ing_last   ( ing_last   ),
        .ing_credit ( ing_credit ),
        .cfg_wr     ( cfg_wr     ),
        .cfg_key    ( cfg_key    ),
        .cfg_port   ( cfg_port   ),
        .cfg_en     ( cfg_en     ),
        .egr_valid  ( egr_valid  ),
        .egr_last   ( egr_last   ),
        .egr_credit ( egr_credit ),
        .egr_data   ( egr_data   ),
        .egr_src    ( egr_src    ),
        .drop_count ( drop_count )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Main process samples well after the edge
    task automatic step();
        @(posedge clk);
        #5;
    endtask

    ////////////////////////////////////////
    // Ingress senders

    initial begin
        ing_valid = '0;
        ing_last  = '0;
        for (int p = 0; p < ING_PORTS; p++) begin
            ing_data[p] = '0;
            snd_rd[p]   = 0;
            sent[p]     = 0;
        end
        forever begin
            @(posedge clk);
            #1;
            for (int p = 0; p < ING_PORTS; p++) begin
                // Send only while a credit is held
                if (rst_n && snd_rd[p] < snd_q[p].size()
                        && sent[p] - credits_back[p] < BUF_DEPTH) begin
                    ing_valid[p] = 1'b1;
                    ing_data[p]  = snd_q[p][snd_rd[p]][DATA_W-1:0];
                    ing_last[p]  = snd_q[p][snd_rd[p]][DATA_W];
                    snd_rd[p]++;
                    sent[p]++;
                end else begin
                    ing_valid[p] = 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Egress credit return

    initial begin
        egr_credit = '0;
        for (int p = 0; p < EGR_PORTS; p++) begin
            credits_sent[p] = 0;
            gap[p]          = 0;
        end
        forever begin
            @(posedge clk);
            #1;
            for (int p = 0; p < EGR_PORTS; p++) begin
                egr_credit[p] = 1'b0;
                if (!hold && beats_seen[p] > credits_sent[p]) begin
                    if (gap[p] == 0) begin
                        egr_credit[p] = 1'b1;
                        credits_sent[p]++;
                        gap[p] = $urandom % 4;
                    end else begin
                        gap[p]--;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////
    // Egress monitor

    task automatic check_beat(input int p);
        int              idx;
        logic [DATA_W:0] want;
        idx = p * ING_PORTS + int'(egr_src);
        beats_seen[p]++;
        // A pulse driven this cycle is not yet seen by the DUT
        if (beats_seen[p] > EGR_CREDITS + credits_sent[p] - int'(egr_credit[p])) begin
            stream_errors++;
            $display("Port %0d sent a beat beyond the credits it was granted", p);
        end
        if (in_pkt[p] && egr_src != cur_src[p]) begin
            stream_errors++;
            $display("Port %0d switched source in the middle of a packet", p);
        end
        in_pkt[p]  = !egr_last[p];
        cur_src[p] = egr_src;
        if (exp_rd[idx] >= exp_q[idx].size()) begin
            stream_errors++;
            $display("Port %0d got a beat from source %0d that was not expected", p, egr_src);
        end else begin
            want = exp_q[idx][exp_rd[idx]];
            exp_rd[idx]++;
            if (egr_data != want[DATA_W-1:0]) begin
                stream_errors++;
                $display("Error at %0t: egr_data on port %0d expected %h got %h",
                         $time, p, want[DATA_W-1:0], egr_data);
            end
            if (egr_last[p] != want[DATA_W]) begin
                stream_errors++;
                $display("Error at %0t: egr_last[%0d] expected %b got %b",
                         $time, p, want[DATA_W], egr_last[p]);
            end
        end
    endtask

    initial begin
        stream_errors = 0;
        in_pkt        = '0;
        for (int p = 0; p < EGR_PORTS; p++) begin
            beats_seen[p] = 0;
            cur_src[p]    = '0;
        end
        for (int p = 0; p < ING_PORTS; p++) begin
            credits_back[p] = 0;
        end
        for (int i = 0; i < QUEUES; i++) begin
            exp_rd[i] = 0;
        end
        forever begin
            @(negedge clk);
            if (rst_n) begin
                for (int p = 0; p < ING_PORTS; p++) begin
                    if (ing_credit[p]) begin
                        credits_back[p]++;
                    end
                end
                for (int p = 0; p < EGR_PORTS; p++) begin
                    if (egr_valid[p]) begin
                        check_beat(p);
                    end
                end
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus

    task automatic program_key(input logic [KEY_W-1:0] key, input egr_idx_t port,
                               input logic en);
        @(posedge clk);
        #1;
        cfg_wr   = 1'b1;
        cfg_key  = key;
        cfg_port = port;
        cfg_en   = en;
        @(posedge clk);
        #1;
        cfg_wr           = 1'b0;
        shadow_en[key]   = en;
        shadow_port[key] = port;
    endtask

    task automatic queue_packet(input int r);
        row_t              row;
        logic              drop;
        egr_idx_t          port;
        logic [DATA_W-1:0] data;
        logic [DATA_W:0]   beat;
        row  = ROWS[r];
        // Outcome follows the table as written so far
        drop = !shadow_en[row.key];
        port = shadow_port[row.key];
        if (drop != row.exp_drop || (!drop && port != row.exp_port)) begin
            errors++;
            $display("Row %0d expects an outcome the written route table does not give", r);
        end
        for (int b = 0; b < int'(row.len); b++) begin
            data = $urandom;
            if (b == 0) begin
                data[KEY_W-1:0] = row.key;
            end
            beat = {(b == int'(row.len) - 1), data};
            snd_q[row.ing].push_back(beat);
            if (!drop) begin
                exp_q[int'(port) * ING_PORTS + int'(row.ing)].push_back(beat);
            end
        end
        if (drop) begin
            exp_drops++;
        end
    endtask

    function automatic bit drained();
        bit done;
        done = (int'(drop_count) == exp_drops);
        for (int p = 0; p < ING_PORTS; p++) begin
            if (snd_rd[p] != snd_q[p].size()) begin
                done = 1'b0;
            end
        end
        for (int i = 0; i < QUEUES; i++) begin
            if (exp_rd[i] != exp_q[i].size()) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    task automatic wait_drain(input int ph);
        int cycles;
        cycles = 0;
        while (!drained() && cycles < DRAIN_LIMIT) begin
            step();
            cycles++;
        end
        if (!drained()) begin
            timeouts++;
            $display("Timeout: traffic of phase %0d did not drain in %0d cycles",
                     ph, DRAIN_LIMIT);
        end
        if (int'(drop_count) != exp_drops) begin
            errors++;
            $display("Error at %0t: drop_count expected %0d got %0d",
                     $time, exp_drops, drop_count);
        end
    endtask

    task automatic check_idle();
        for (int c = 0; c < 5; c++) begin
            step();
            if (egr_valid != '0) begin
                errors++;
                $display("Error at %0t: egr_valid expected 00 got %b", $time, egr_valid);
            end
            if (ing_credit != '0) begin
                errors++;
                $display("Error at %0t: ing_credit expected 00 got %b", $time, ing_credit);
            end
        end
    endtask

    // Writes first, then all packets of the phase at once
    task automatic run_phase(input int ph);
        for (int r = 0; r < NROWS; r++) begin
            if (int'(ROWS[r].phase) == ph && ROWS[r].prog) begin
                program_key(ROWS[r].key, ROWS[r].prog_port, ROWS[r].prog_en);
            end
        end
        hold = (ph == HOLD_PHASE);
        for (int r = 0; r < NROWS; r++) begin
            if (int'(ROWS[r].phase) == ph) begin
                queue_packet(r);
            end
        end
        if (hold) begin
            repeat (HOLD_CYCLES) step();
            hold = 1'b0;
        end
        wait_drain(ph);
    endtask

    initial begin
        int total;
        rst_n     = 1'b0;
        cfg_wr    = 1'b0;
        cfg_key   = '0;
        cfg_port  = '0;
        cfg_en    = 1'b0;
        hold      = 1'b0;
        errors    = 0;
        timeouts  = 0;
        exp_drops = 0;
        shadow_en = '0;
        for (int k = 0; k < 2**KEY_W; k++) begin
            shadow_port[k] = '0;
        end
        void'($urandom(SEED));
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_idle();
        for (int ph = 0; ph < PHASES; ph++) begin
            run_phase(ph);
        end
        repeat (4) step();
        for (int p = 0; p < ING_PORTS; p++) begin
            if (credits_back[p] != sent[p]) begin
                errors++;
                $display("Error at %0t: ing_credit[%0d] pulses expected %0d got %0d",
                         $time, p, sent[p], credits_back[p]);
            end
        end
        total = errors + stream_errors + timeouts;
        $display("Errors: %0d check, %0d stream, %0d timeout", errors, stream_errors, timeouts);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
